/* dv/texture_datapath_tb.sv */
`timescale 1ns/100ps
`include "texture_defs.svh"

module texture_datapath_tb;
    import texture_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 6;
    localparam int FRAME_PIX  = `IMG_ROWS * `IMG_COLS;
    localparam int INTERIOR   = (`IMG_ROWS - 2) * (`IMG_COLS - 2);

    logic   clk;
    logic   rst;
    pixel_t pixel_i;
    logic   pixel_valid_i;
    logic   read_en_i;
    count_t histogram_o;
    logic   hist_valid_o;
    logic   read_finish_o;
    logic   frame_done_o;

    pixel_t      frame [`IMG_ROWS][`IMG_COLS];
    int          exp_bins [`HIST_BINS];
    int          got_bins [`HIST_BINS];
    logic [31:0] lfsr;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    texture_datapath UUT (
        .clk           (clk),
        .rst           (rst),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .read_en_i     (read_en_i),
        .histogram_o   (histogram_o),
        .hist_valid_o  (hist_valid_o),
        .read_finish_o (read_finish_o),
        .frame_done_o  (frame_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Bound from the test count and frame length
    initial begin
        #(NUM_TESTS * (FRAME_PIX + 100) * 4 * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    // ======================================================================
    // Stimulus and reference model
    // ======================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // x^32+x^22+x^2+x+1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic fill_frame(input int kind);
        logic [31:0] v;
        for (int r = 0; r < `IMG_ROWS; r++) begin
            for (int c = 0; c < `IMG_COLS; c++) begin
                rand_bits(8, v);
                if (kind == 0)
                    frame[r][c] = 8'd97;    // Flat
                else if (kind == 1)
                    frame[r][c] = pixel_t'(v);
                else
                    frame[r][c] = ((r + c) % 2 != 0) ? 8'd200 : 8'd40;
            end
        end
    endtask

    task automatic model_bins();
        int         dr [8] = '{0, -1, -1, -1, 0, 1, 1, 1};    // East, then CCW
        int         dc [8] = '{1, 1, 0, -1, -1, -1, 0, 1};
        int         sum;
        int         thr;
        int         trans;
        int         ones;
        int         label;
        logic [7:0] sgn;
        for (int b = 0; b < `HIST_BINS; b++) exp_bins[b] = 0;
        for (int r = 1; r < `IMG_ROWS - 1; r++) begin
            for (int c = 1; c < `IMG_COLS - 1; c++) begin
                sum = 0;
                for (int k = 0; k < 8; k++) sum += int'(frame[r + dr[k]][c + dc[k]]);
                thr = sum / 8;
                for (int k = 0; k < 8; k++) sgn[k] = int'(frame[r + dr[k]][c + dc[k]]) >= thr;
                trans = 0;
                ones  = 0;
                for (int k = 0; k < 8; k++) begin
                    if (sgn[k] != sgn[(k + 1) % 8]) trans++;
                    if (sgn[k]) ones++;
                end
                label = (trans <= 2) ? ones : 9;
                if (int'(frame[r][c]) >= thr) label += 10;    // CI bit
                exp_bins[label]++;
            end
        end
    endtask

    task automatic send_frame(input string name, input int num_pix, input bit wait_done);
        int waited;
        for (int p = 0; p < num_pix; p++) begin
            @(negedge clk);
            pixel_i       = frame[p / `IMG_COLS][p % `IMG_COLS];
            pixel_valid_i = 1'b1;
        end
        @(negedge clk);
        pixel_valid_i = 1'b0;
        waited        = 0;
        while (wait_done && !frame_done_o && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        assert (!wait_done || frame_done_o) else begin
            $display("%s: frame_done_o never pulsed after the last pixel", name);
            test_errors++;
        end
    endtask

    // ======================================================================
    // Readout check
    // ======================================================================
    task automatic read_bins(input string name, input bit stall);
        logic [31:0] v;
        logic        en_prev;
        int          fired;
        int          got;
        int          finishes;
        int          waited;
        en_prev  = 1'b0;
        fired    = 0;
        got      = 0;
        finishes = 0;
        waited   = 0;
        while (got < `HIST_BINS && waited < 200) begin
            @(negedge clk);
            waited++;
            assert (hist_valid_o == en_prev) else begin
                $display("%s: hist_valid_o did not follow read_en_i of the cycle before",
                         name);
                test_errors++;
            end
            if (hist_valid_o) begin
                got_bins[got] = int'(histogram_o);
                assert (histogram_o == count_t'(exp_bins[got])) else begin
                    $display("ERROR %s: bin %0d expected %0d actual %0d",
                             name, got, exp_bins[got], histogram_o);
                    test_errors++;
                end
                got++;
            end
            if (stall) rand_bits(1, v);
            else v = 32'd1;
            read_en_i = (fired < `HIST_BINS) && v[0];
            en_prev   = read_en_i;
            if (read_en_i) fired++;
        end
        read_en_i = 1'b0;
        assert (got == `HIST_BINS) else begin
            $display("%s: only %0d of %0d bins came out", name, got, `HIST_BINS);
            test_errors++;
        end
        // Finish pulse, then rearm
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            if (read_finish_o) finishes++;
            assert (!hist_valid_o) else begin
                $display("%s: hist_valid_o rose after the last bin", name);
                test_errors++;
            end
        end
        assert (finishes == 1) else begin
            $display("ERROR %s: read_finish_o pulses expected 1 actual %0d", name, finishes);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        errors      += test_errors;
        test_errors  = 0;
    endtask

    // ======================================================================
    // Tests
    // ======================================================================
    task automatic run_tests();
        int sum;
        // Flat frame lands entirely in bin 18
        fill_frame(0);
        for (int b = 0; b < `HIST_BINS; b++) exp_bins[b] = (b == 18) ? INTERIOR : 0;
        send_frame("flat_frame", FRAME_PIX, 1'b1);
        read_bins("flat_frame", 1'b0);
        finish_test("flat_frame");

        fill_frame(1);
        model_bins();
        send_frame("random_frame", FRAME_PIX, 1'b1);
        read_bins("random_frame", 1'b0);
        sum = 0;
        for (int b = 0; b < `HIST_BINS; b++) sum += got_bins[b];
        assert (sum == INTERIOR) else begin
            $display("ERROR random_frame: bin sum expected %0d actual %0d", INTERIOR, sum);
            test_errors++;
        end
        finish_test("random_frame");

        fill_frame(1);
        model_bins();
        send_frame("stalled_read", FRAME_PIX, 1'b1);
        read_bins("stalled_read", 1'b1);
        finish_test("stalled_read");

        // The first dump clears the counters for the second frame
        fill_frame(1);
        send_frame("back_to_back", FRAME_PIX, 1'b1);
        fill_frame(2);
        model_bins();
        send_frame("back_to_back", FRAME_PIX, 1'b1);
        read_bins("back_to_back", 1'b0);
        finish_test("back_to_back");

        fill_frame(1);
        model_bins();
        send_frame("read_twice", FRAME_PIX, 1'b1);
        read_bins("read_twice", 1'b0);
        read_bins("read_twice", 1'b0);
        finish_test("read_twice");

        fill_frame(1);
        send_frame("reset_mid_frame", FRAME_PIX / 2 + 5, 1'b0);
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        fill_frame(1);
        model_bins();
        send_frame("reset_mid_frame", FRAME_PIX, 1'b1);
        read_bins("reset_mid_frame", 1'b0);
        finish_test("reset_mid_frame");
    endtask

    initial begin
        rst           = 1'b1;
        pixel_i       = '0;
        pixel_valid_i = 1'b0;
        read_en_i     = 1'b0;
        lfsr          = 32'hd8a1_141a;
        errors        = 0;
        test_errors   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        run_tests();
        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* include/texture_defs.svh */
`ifndef TEXTURE_DEFS_SVH
`define TEXTURE_DEFS_SVH

// Frame geometry
`define IMG_COLS 16
`define IMG_ROWS 16

// Datapath widths
`define PIX_W 8
`define CNT_W 16

// Joint CI/NI histogram
`define NI_BINS 10    // Labels 0 to 9 per centre bit
`define HIST_BINS 20

`endif

/* logic/histogram_readout.sv */
`timescale 1ns/100ps
`include "texture_defs.svh"

module histogram_readout (
    input  logic                clk,
    input  logic                rst,
    input  logic                dump_valid_i,
    input  texture_pkg::bin_t   dump_addr_i,
    input  texture_pkg::count_t dump_count_i,
    input  logic                read_en_i,
    output logic                frame_done_o,
    output logic                hist_valid_o,
    output texture_pkg::count_t histogram_o,
    output logic                read_finish_o
);
    import texture_pkg::*;

    localparam bin_t LAST_BIN = bin_t'(`HIST_BINS - 1);

    count_t    mem [`HIST_BINS];
    rd_state_t rd_state;
    bin_t      rd_addr;
    logic      rd_fire;

    // ======================================================================
    // Write side
    // ======================================================================
    always_ff @(posedge clk) begin
        if (dump_valid_i) begin
            mem[dump_addr_i] <= dump_count_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_done_o <= 1'b0;
        end else begin
            frame_done_o <= dump_valid_i && (dump_addr_i == LAST_BIN);
        end
    end

    // ======================================================================
    // Read side
    // ======================================================================
    assign rd_fire = read_en_i && ((rd_state == IDLE) || (rd_state == READ));

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state      <= IDLE;
            rd_addr       <= '0;
            hist_valid_o  <= 1'b0;
            read_finish_o <= 1'b0;
        end else begin
            hist_valid_o  <= rd_fire;    // Low on any stalled cycle
            read_finish_o <= 1'b0;
            case (rd_state)
                IDLE: begin
                    if (read_en_i) begin
                        rd_addr  <= rd_addr + 1'b1;
                        rd_state <= READ;
                    end
                end
                READ: begin
                    if (read_en_i) begin
                        if (rd_addr == LAST_BIN) begin
                            rd_addr  <= '0;
                            rd_state <= FINISH;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end
                end
                FINISH: begin
                    read_finish_o <= 1'b1;
                    rd_state      <= REARM;
                end
                REARM:   rd_state <= IDLE;
                default: rd_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            histogram_o <= mem[rd_addr];
        end
    end

endmodule

/* logic/joint_histogram.sv */
`timescale 1ns/100ps
`include "texture_defs.svh"

module joint_histogram (
    input  logic                clk,
    input  logic                rst,
    input  logic                code_valid_i,
    input  logic                ci_i,
    input  texture_pkg::label_t label_i,
    input  logic                code_last_i,
    output logic                dump_valid_o,
    output texture_pkg::bin_t   dump_addr_o,
    output texture_pkg::count_t dump_count_o
);
    import texture_pkg::*;

    localparam bin_t LAST_BIN = bin_t'(`HIST_BINS - 1);

    count_t cnt [`HIST_BINS];
    bin_t   bin_idx;
    bin_t   dump_idx;
    logic   dumping;

    // CI selects the upper half of the bins
    assign bin_idx = bin_t'(ci_i ? `NI_BINS : 0) + bin_t'(label_i);

    // ======================================================================
    // Counting and clear-on-dump
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < `HIST_BINS; b++) begin
                cnt[b] <= '0;
            end
            dumping      <= 1'b0;
            dump_idx     <= '0;
            dump_valid_o <= 1'b0;
        end else begin
            dump_valid_o <= dumping;
            if (code_valid_i) begin
                cnt[bin_idx] <= cnt[bin_idx] + 1'b1;
            end
            if (code_valid_i && code_last_i) begin
                dumping <= 1'b1;    // Frame complete
            end
            if (dumping) begin
                cnt[dump_idx] <= '0;
                if (dump_idx == LAST_BIN) begin
                    dumping  <= 1'b0;
                    dump_idx <= '0;
                end else begin
                    dump_idx <= dump_idx + 1'b1;
                end
            end
        end
    end

    // Dump payload
    always_ff @(posedge clk) begin
        if (dumping) begin
            dump_addr_o  <= dump_idx;
            dump_count_o <= cnt[dump_idx];
        end
    end

endmodule

/* logic/lbp_riu2_encoder.sv */
`timescale 1ns/100ps
`include "texture_defs.svh"

module lbp_riu2_encoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                win_valid_i,
    input  logic                frame_end_i,
    input  texture_pkg::pixel_t c_i,
    input  texture_pkg::pixel_t n0_i,
    input  texture_pkg::pixel_t n1_i,
    input  texture_pkg::pixel_t n2_i,
    input  texture_pkg::pixel_t n3_i,
    input  texture_pkg::pixel_t n4_i,
    input  texture_pkg::pixel_t n5_i,
    input  texture_pkg::pixel_t n6_i,
    input  texture_pkg::pixel_t n7_i,
    output logic                code_valid_o,
    output logic                ci_o,
    output texture_pkg::label_t label_o,
    output logic                code_last_o
);
    import texture_pkg::*;

    localparam int     SUM_W    = `PIX_W + 3;    // Eight pixels summed
    localparam label_t NONUNIF  = label_t'(9);

    logic             s1_valid;
    logic             s1_last;
    logic [SUM_W-1:0] s1_sum;
    pixel_t           s1_c;
    pixel_t           s1_n [8];

    pixel_t     thr;
    logic [7:0] sgn;
    logic [3:0] trans;
    logic [3:0] ones;
    label_t     lbl;

    // ======================================================================
    // Stage 1 neighbour sum
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= win_valid_i;
            s1_last  <= win_valid_i && frame_end_i;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            s1_sum <= SUM_W'(n0_i) + SUM_W'(n1_i) + SUM_W'(n2_i) + SUM_W'(n3_i)
                    + SUM_W'(n4_i) + SUM_W'(n5_i) + SUM_W'(n6_i) + SUM_W'(n7_i);
            s1_c    <= c_i;
            s1_n[0] <= n0_i;
            s1_n[1] <= n1_i;
            s1_n[2] <= n2_i;
            s1_n[3] <= n3_i;
            s1_n[4] <= n4_i;
            s1_n[5] <= n5_i;
            s1_n[6] <= n6_i;
            s1_n[7] <= n7_i;
        end
    end

    // ======================================================================
    // Stage 2 signs, uniformity and label
    // ======================================================================
    always_comb begin
        thr   = pixel_t'(s1_sum >> 3);    // Neighbour mean
        trans = '0;
        ones  = '0;
        for (int k = 0; k < 8; k++) begin
            sgn[k] = (s1_n[k] >= thr);
        end
        for (int k = 0; k < 8; k++) begin
            trans = trans + 4'(sgn[k] ^ sgn[(k + 1) % 8]);
            ones  = ones + 4'(sgn[k]);
        end
        lbl = (trans <= 4'd2) ? label_t'(ones) : NONUNIF;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            code_valid_o <= 1'b0;
            code_last_o  <= 1'b0;
        end else begin
            code_valid_o <= s1_valid;
            code_last_o  <= s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            label_o <= lbl;
            ci_o    <= (s1_c >= thr);
        end
    end

endmodule

/* logic/texture_datapath.sv */
`timescale 1ns/100ps

module texture_datapath (
    input  logic                clk,
    input  logic                rst,
    input  texture_pkg::pixel_t pixel_i,
    input  logic                pixel_valid_i,
    input  logic                read_en_i,
    output texture_pkg::count_t histogram_o,
    output logic                hist_valid_o,
    output logic                read_finish_o,
    output logic                frame_done_o
);
    import texture_pkg::*;

    logic   win_valid;
    logic   frame_end;
    pixel_t win_c;
    pixel_t win_n [8];

    logic   code_valid;
    logic   code_ci;
    label_t code_label;
    logic   code_last;

    logic   dump_valid;
    bin_t   dump_addr;
    count_t dump_count;

    // ======================================================================
    // Neighbourhood and coding
    // ======================================================================
    window_3x3 u_window (
        .clk         (clk),
        .rst         (rst),
        .pix_i       (pixel_i),
        .pix_valid_i (pixel_valid_i),
        .win_valid_o (win_valid),
        .frame_end_o (frame_end),
        .c_o         (win_c),
        .n0_o        (win_n[0]),
        .n1_o        (win_n[1]),
        .n2_o        (win_n[2]),
        .n3_o        (win_n[3]),
        .n4_o        (win_n[4]),
        .n5_o        (win_n[5]),
        .n6_o        (win_n[6]),
        .n7_o        (win_n[7])
    );

    lbp_riu2_encoder u_encoder (
        .clk          (clk),
        .rst          (rst),
        .win_valid_i  (win_valid),
        .frame_end_i  (frame_end),
        .c_i          (win_c),
        .n0_i         (win_n[0]),
        .n1_i         (win_n[1]),
        .n2_i         (win_n[2]),
        .n3_i         (win_n[3]),
        .n4_i         (win_n[4]),
        .n5_i         (win_n[5]),
        .n6_i         (win_n[6]),
        .n7_i         (win_n[7]),
        .code_valid_o (code_valid),
        .ci_o         (code_ci),
        .label_o      (code_label),
        .code_last_o  (code_last)
    );

    // ======================================================================
    // Histogram and readout
    // ======================================================================
    joint_histogram u_histogram (
        .clk          (clk),
        .rst          (rst),
        .code_valid_i (code_valid),
        .ci_i         (code_ci),
        .label_i      (code_label),
        .code_last_i  (code_last),
        .dump_valid_o (dump_valid),
        .dump_addr_o  (dump_addr),
        .dump_count_o (dump_count)
    );

    histogram_readout u_readout (
        .clk           (clk),
        .rst           (rst),
        .dump_valid_i  (dump_valid),
        .dump_addr_i   (dump_addr),
        .dump_count_i  (dump_count),
        .read_en_i     (read_en_i),
        .frame_done_o  (frame_done_o),
        .hist_valid_o  (hist_valid_o),
        .histogram_o   (histogram_o),
        .read_finish_o (read_finish_o)
    );

endmodule

/* logic/texture_pkg.sv */
`include "texture_defs.svh"

package texture_pkg;

    // Grayscale sample
    typedef logic [`PIX_W-1:0] pixel_t;

    // Rotation-invariant uniform neighbour label
    typedef logic [3:0] label_t;

    typedef logic [4:0] bin_t;    // Joint bin index
    typedef logic [`CNT_W-1:0] count_t;

    // Read side of the bin memory
    typedef enum logic [1:0] {
        IDLE,
        READ,
        FINISH,
        REARM
    } rd_state_t;

endpackage

/* logic/window_3x3.sv */
`timescale 1ns/100ps
`include "texture_defs.svh"

module window_3x3 (
    input  logic                clk,
    input  logic                rst,
    input  texture_pkg::pixel_t pix_i,
    input  logic                pix_valid_i,
    output logic                win_valid_o,
    output logic                frame_end_o,
    output texture_pkg::pixel_t c_o,
    output texture_pkg::pixel_t n0_o,
    output texture_pkg::pixel_t n1_o,
    output texture_pkg::pixel_t n2_o,
    output texture_pkg::pixel_t n3_o,
    output texture_pkg::pixel_t n4_o,
    output texture_pkg::pixel_t n5_o,
    output texture_pkg::pixel_t n6_o,
    output texture_pkg::pixel_t n7_o
);
    import texture_pkg::*;

    localparam int COL_W = $clog2(`IMG_COLS);
    localparam int ROW_W = $clog2(`IMG_ROWS);

    pixel_t lb0 [`IMG_COLS];    // One row back
    pixel_t lb1 [`IMG_COLS];    // Two rows back
    pixel_t win [3][3];         // [row][col], row 0 is the oldest

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             col_last;
    logic             row_last;
    logic             interior;

    // ======================================================================
    // Position of the incoming pixel
    // ======================================================================
    assign col_last = (col == COL_W'(`IMG_COLS - 1));
    assign row_last = (row == ROW_W'(`IMG_ROWS - 1));

    // Centre sits one row and one column behind the incoming pixel
    assign interior = (row >= ROW_W'(2)) && (col >= COL_W'(2));

    always_ff @(posedge clk) begin
        if (rst) begin
            col         <= '0;
            row         <= '0;
            win_valid_o <= 1'b0;
            frame_end_o <= 1'b0;
        end else begin
            win_valid_o <= pix_valid_i && interior;
            frame_end_o <= pix_valid_i && row_last && col_last;
            if (pix_valid_i) begin
                if (col_last) begin
                    col <= '0;
                    row <= row_last ? '0 : row + 1'b1;    // Wrap per frame
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // ======================================================================
    // Line buffers and shift window
    // ======================================================================
    always_ff @(posedge clk) begin
        if (pix_valid_i) begin
            lb0[col] <= pix_i;
            lb1[col] <= lb0[col];
            for (int r = 0; r < 3; r++) begin
                win[r][0] <= win[r][1];
                win[r][1] <= win[r][2];
            end
            // New right column
            win[0][2] <= lb1[col];
            win[1][2] <= lb0[col];
            win[2][2] <= pix_i;
        end
    end

    // East first, then counter-clockwise
    assign c_o  = win[1][1];
    assign n0_o = win[1][2];
    assign n1_o = win[0][2];
    assign n2_o = win[0][1];
    assign n3_o = win[0][0];
    assign n4_o = win[1][0];
    assign n5_o = win[2][0];
    assign n6_o = win[2][1];
    assign n7_o = win[2][2];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the texture datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=texture_datapath_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module "$TOP" -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation completed without failure"
exit 0

/* verilog.f */
+incdir+include
logic/texture_pkg.sv
logic/window_3x3.sv
logic/lbp_riu2_encoder.sv
logic/joint_histogram.sv
logic/histogram_readout.sv
logic/texture_datapath.sv
dv/texture_datapath_tb.sv
